// File: common/uart_consts.svh
// frame and buffer constants for the UART transmitter
// include wherever a width, count or depth is needed

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////////////////////////
// frame format
////////////////////////////////////////

// data bits per frame, lsb goes out first
`define UART_DATA_BITS      8

// oversample ticks per start or data bit
`define UART_OVERSAMPLE     16

// stop bit length in ticks (16 = one stop bit)
`define UART_STOP_TICKS     16

////////////////////////////////////////
// transmit buffer
////////////////////////////////////////

`define UART_FIFO_DEPTH     16  // entries
`define UART_FIFO_ADDR_BITS 4   // log2 of depth

////////////////////////////////////////
// baud tick generator
////////////////////////////////////////

// divisor width, tick period is divisor+1 clocks
`define UART_BAUD_DIV_BITS  16

`endif

// File: common/uartPkg.sv
// shared types for the UART transmitter
// modules pull these in with a wildcard import

`default_nettype none

`include "uart_consts.svh"

package uartPkg;

	////////////////////////////////////////
	// vector types
	////////////////////////////////////////

	typedef logic [`UART_DATA_BITS-1:0] uartByte_t;     // one payload byte
	typedef logic [4:0] tickCount_t;                    // tick index, stop ticks up to 32
	typedef logic [2:0] bitIndex_t;                     // which data bit is on the line
	typedef logic [`UART_FIFO_ADDR_BITS:0] fifoLevel_t; // 0..depth, one extra bit
	typedef logic [`UART_BAUD_DIV_BITS-1:0] baudDiv_t;  // tick divisor

	// transmit FSM
	typedef enum logic [1:0]
	{
		idle  = 2'b00,
		start = 2'b01,
		data  = 2'b10,
		stop  = 2'b11
	} txState_t;

	////////////////////////////////////////
	// grouped signals
	////////////////////////////////////////

	// controller commands to the shifter
	typedef struct packed
	{
		logic load;  // capture FIFO head
		logic shift; // next data bit
	} txCtrl_t;

	// FIFO status for the host and the controller
	typedef struct packed
	{
		logic       full;
		logic       empty;
		fifoLevel_t level; // entries held
	} fifoStat_t;

endpackage

`default_nettype wire

// File: source/baudGen.sv
// oversample tick generator, one clk-wide pulse every baudDiv+1 cycles
// divisor may change at run time, new value is used from the next compare

`timescale 1ns/1ns
`default_nettype none

module baudGen import uartPkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  baudDiv_t baudDiv, // period minus one
	output logic     tick
);

	baudDiv_t count; // free running, wraps at the divisor

	////////////////////////////////////////
	// divider
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (count >= baudDiv) // >= so a smaller new divisor wraps at once
		begin
			count <= '0;
			tick <= 1'b1;
		end
		else
		begin
			count <= count + 1'b1;
			tick <= 1'b0;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// a nonzero divisor always leaves a gap after each tick
	assert property (@(posedge clk) disable iff (reset)
		(tick && (baudDiv != '0)) |=> !tick);

endmodule

`default_nettype wire

// File: source/txFifo.sv
// transmit byte buffer, circular with an occupancy counter
// head is visible combinationally on rdData, writes while full are lost

`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module txFifo import uartPkg::*;
#(
	parameter int DEPTH = `UART_FIFO_DEPTH
)
(
	input  logic      clk,
	input  logic      reset,
	input  uartByte_t wrData,
	input  logic      wrEn,   // plain strobe, no handshake
	input  logic      pop,    // one-cycle pulse from the controller
	output uartByte_t rdData, // current head
	output fifoStat_t stat
);

	localparam int AW = $clog2(DEPTH);

	uartByte_t  mem [DEPTH]; // storage, no reset needed
	logic [AW-1:0] wrPtr;
	logic [AW-1:0] rdPtr;
	fifoLevel_t count;
	logic doWrite;
	logic doPop;

	assign doWrite = wrEn && !stat.full; // drop when full
	assign doPop = pop && !stat.empty;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	assign rdData = mem[rdPtr];

	////////////////////////////////////////
	// pointers and level
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= (wrPtr == AW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // wrap for odd depths
			if (doPop)
				rdPtr <= (rdPtr == AW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			case ({doWrite, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither, level holds
			endcase
		end
	end

	// flags straight from the count
	assign stat.full = (count == fifoLevel_t'(DEPTH));
	assign stat.empty = (count == '0);
	assign stat.level = count;

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	assert property (@(posedge clk) disable iff (reset)
		count <= fifoLevel_t'(DEPTH));

	// controller only pops a non-empty buffer
	assert property (@(posedge clk) disable iff (reset)
		pop |-> !stat.empty);

endmodule

`default_nettype wire

// File: uart/txControl.sv
// transmit FSM: start bit, data bits lsb first, stop bit
// pops the FIFO and loads the shifter in the same cycle, tx is registered

`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module txControl import uartPkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    tick,      // oversample pulse
	input  logic    fifoEmpty,
	input  logic    dataBit,   // shifter lsb
	output logic    pop,
	output txCtrl_t ctrl,
	output logic    tx,        // serial line
	output logic    busy
);

	localparam tickCount_t lastBitTick = tickCount_t'(`UART_OVERSAMPLE - 1);
	localparam tickCount_t lastStopTick = tickCount_t'(`UART_STOP_TICKS - 1);
	localparam bitIndex_t lastDataBit = bitIndex_t'(`UART_DATA_BITS - 1);

	txState_t   state;
	tickCount_t tickCnt; // ticks into the current bit
	bitIndex_t  bitCnt;  // data bit on the line
	logic bitDone;       // last tick of a start or data bit
	logic stopDone;      // last tick of the stop bit

	assign bitDone = tick && (tickCnt == lastBitTick);
	assign stopDone = tick && (tickCnt == lastStopTick);

	////////////////////////////////////////
	// command outputs
	////////////////////////////////////////

	assign pop = (state == idle) && !fifoEmpty; // head goes to the shifter on this edge
	assign ctrl.load = pop;
	assign ctrl.shift = (state == data) && bitDone; // also on the last bit, harmless
	assign busy = (state != idle);

	////////////////////////////////////////
	// state and counters
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			tickCnt <= '0;
			bitCnt <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					tickCnt <= '0;
					bitCnt <= '0;
					if (pop)
						state <= start;
				end
				start:
				begin
					if (bitDone)
					begin
						state <= data;
						tickCnt <= '0;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				data:
				begin
					if (bitDone)
					begin
						tickCnt <= '0;
						if (bitCnt == lastDataBit) // last data bit done
							state <= stop;
						else
							bitCnt <= bitCnt + 1'b1;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				stop:
				begin
					if (stopDone)
					begin
						state <= idle; // one idle cycle before the next pop
						tickCnt <= '0;
					end
					else if (tick)
						tickCnt <= tickCnt + 1'b1;
				end
				default: state <= idle;
			endcase
		end
	end

	////////////////////////////////////////
	// line driver, one cycle behind state
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			tx <= 1'b1; // line rests high
		else
		begin
			case (state)
				start:   tx <= 1'b0;
				data:    tx <= dataBit;
				default: tx <= 1'b1; // idle and stop
			endcase
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// a pop starts a frame on the next cycle
	assert property (@(posedge clk) disable iff (reset)
		pop |-> !busy ##1 (busy && !pop));

	// the registered line settles high by the time idle is reached
	assert property (@(posedge clk) disable iff (reset)
		(state == idle) |-> tx);

	assert property (@(posedge clk) disable iff (reset)
		!(ctrl.load && ctrl.shift));

endmodule

`default_nettype wire

// File: uart/txShifter.sv
// frame data register, loads a byte and shifts right one bit per data bit
// lsb is the bit currently due on the line

`timescale 1ns/1ns
`default_nettype none

module txShifter import uartPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  txCtrl_t   ctrl,    // load / shift from the controller
	input  uartByte_t din,     // FIFO head
	output logic      dataBit
);

	uartByte_t shiftReg;

	////////////////////////////////////////
	// shift register
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			shiftReg <= '0;
		else if (ctrl.load)
			shiftReg <= din; // same edge as the FIFO pop
		else if (ctrl.shift)
			shiftReg <= {1'b0, shiftReg[$bits(uartByte_t)-1:1]}; // right, lsb first
	end

	assign dataBit = shiftReg[0];

endmodule

`default_nettype wire

// File: source/uartTxTop.sv
// buffered UART transmitter top level
// host writes bytes with wrEn and watches fifoStat.full, frames leave on tx

`timescale 1ns/1ns
`default_nettype none

module uartTxTop import uartPkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  baudDiv_t  baudDiv,  // tick period minus one
	input  uartByte_t wrData,
	input  logic      wrEn,
	output logic      tx,
	output logic      busy,     // frame in progress
	output fifoStat_t fifoStat
);

	logic      tick;
	logic      pop;
	uartByte_t rdData;  // FIFO head
	txCtrl_t   ctrl;
	logic      dataBit;

	baudGen uBaud
	(
		.clk     (clk),
		.reset   (reset),
		.baudDiv (baudDiv),
		.tick    (tick)
	);

	txFifo uFifo
	(
		.clk    (clk),
		.reset  (reset),
		.wrData (wrData),
		.wrEn   (wrEn),
		.pop    (pop),
		.rdData (rdData),
		.stat   (fifoStat)
	);

	txControl uCtrl
	(
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.fifoEmpty (fifoStat.empty),
		.dataBit   (dataBit),
		.pop       (pop),
		.ctrl      (ctrl),
		.tx        (tx),
		.busy      (busy)
	);

	txShifter uShift
	(
		.clk     (clk),
		.reset   (reset),
		.ctrl    (ctrl),
		.din     (rdData),
		.dataBit (dataBit)
	);

endmodule

`default_nettype wire

// File: tb/tbUartTx.sv
// random-stimulus testbench for the buffered UART transmitter
// decodes tx frames and checks them against a queue of accepted writes

`timescale 1ns/1ns
`default_nettype none

`include "uart_consts.svh"

module tbUartTx import uartPkg::*;
();

	localparam logic [31:0] seed = 32'h8ec0;
	localparam int bytesPerRun = 20;   // random bytes per divisor run
	localparam int burstLen = 24;      // back-to-back writes, overfills the FIFO
	localparam int maxGap = 12;        // idle cycles between random writes
	localparam int maxDiv = 7;
	localparam int totalBytes = 3 * bytesPerRun + burstLen;
	localparam int frameBits = `UART_DATA_BITS + 2; // start, data, stop
	localparam int timeoutCycles =
		totalBytes * frameBits * `UART_OVERSAMPLE * (maxDiv + 1) + 2000;

	logic      clk;
	logic      reset;
	baudDiv_t  baudDiv;
	uartByte_t wrData;
	logic      wrEn;
	logic      tx;
	logic      busy;
	fifoStat_t fifoStat;

	uartByte_t expected [$]; // accepted bytes, oldest first
	int  cycleCount;
	int  acceptedCount;
	int  droppedCount;
	logic sawFull;
	logic prevTx;
	logic prevBusy;
	logic prevEmpty;
	logic decActive;  // line decoder inside a frame
	int   decCount;   // cycles since the start edge
	int   decBit;     // next bit to sample, 0 = start
	uartByte_t decByte;
	uartByte_t wantByte;

	uartTxTop uut
	(
		.clk      (clk),
		.reset    (reset),
		.baudDiv  (baudDiv),
		.wrData   (wrData),
		.wrEn     (wrEn),
		.tx       (tx),
		.busy     (busy),
		.fifoStat (fifoStat)
	);

	always #2 clk = ~clk; // 4 ns period

	////////////////////////////////////////
	// reporting
	////////////////////////////////////////

	task automatic stopWithError(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic compareValue(input string name, input logic [31:0] want,
		input logic [31:0] got);
		if (want !== got)
			stopWithError($sformatf("[FAIL] %s expected 0x%0h actual 0x%0h", name, want, got));
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles)
			stopWithError("timeout: the transmitter did not finish in the allowed cycles");
	end

	////////////////////////////////////////
	// monitor and line decoder, on negedge
	////////////////////////////////////////

	always @(negedge clk)
	begin
		if (!reset)
		begin
			// reference queue, a write counts if the FIFO was not full
			if (wrEn && !fifoStat.full)
			begin
				expected.push_back(wrData);
				acceptedCount = acceptedCount + 1;
			end
			else if (wrEn)
				droppedCount = droppedCount + 1;
			if (fifoStat.full)
				sawFull = 1'b1;

			// idle with data waiting lasts one cycle only
			if (!prevBusy && !prevEmpty)
				compareValue("busy", 32'd1, 32'(busy));

			if (!decActive)
			begin
				if (prevTx && !tx) // start edge
				begin
					decActive = 1'b1;
					decCount = 0;
					decBit = 0;
					decByte = '0;
				end
			end
			else
				decCount = decCount + 1;

			// sample at the middle of each bit
			if (decActive && decCount ==
				(`UART_OVERSAMPLE * decBit + `UART_OVERSAMPLE / 2) * (int'(baudDiv) + 1))
			begin
				if (decBit == 0)
					compareValue("tx start bit", 32'd0, 32'(tx));
				else if (decBit <= `UART_DATA_BITS)
					decByte[decBit-1] = tx; // lsb first
				else
				begin
					compareValue("tx stop bit", 32'd1, 32'(tx));
					if (expected.size() == 0)
						stopWithError("a frame was decoded with no accepted byte waiting");
					wantByte = expected.pop_front();
					compareValue("tx decoded byte", 32'(wantByte), 32'(decByte));
					decActive = 1'b0;
				end
				decBit = decBit + 1;
			end
		end
		prevTx = tx;
		prevBusy = busy;
		prevEmpty = fifoStat.empty;
	end

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	task automatic sendRandomBytes(input int count);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			wrEn <= 1'b1;
			wrData <= uartByte_t'($urandom);
			@(posedge clk);
			wrEn <= 1'b0;
			gap = $urandom_range(maxGap, 0);
			repeat (gap) @(posedge clk);
		end
	endtask

	// one write per cycle, no gaps
	task automatic sendBurst(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			wrEn <= 1'b1;
			wrData <= uartByte_t'($urandom);
		end
		@(posedge clk);
		wrEn <= 1'b0;
	endtask

	// all accepted bytes decoded, then the FSM must drop busy within the stop bit
	task automatic waitForIdle();
		int limit;
		int waited;
		@(negedge clk);
		while (expected.size() != 0 || decActive)
			@(negedge clk);
		// rest of the stop bit after its middle sample, plus slack
		limit = (`UART_STOP_TICKS / 2 + 2) * (int'(baudDiv) + 1);
		waited = 0;
		while (busy && waited < limit)
		begin
			@(negedge clk);
			waited = waited + 1;
		end
		compareValue("busy", 32'd0, 32'(busy));
		compareValue("fifoStat.empty", 32'd1, 32'(fifoStat.empty));
		compareValue("tx", 32'd1, 32'(tx));
	endtask

	task automatic setDivisor(input int value);
		@(posedge clk);
		baudDiv <= baudDiv_t'(value);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		baudDiv = baudDiv_t'(3);
		wrData = '0;
		wrEn = 1'b0;
		cycleCount = 0;
		acceptedCount = 0;
		droppedCount = 0;
		sawFull = 1'b0;
		prevTx = 1'b1;
		prevBusy = 1'b0;
		prevEmpty = 1'b1;
		decActive = 1'b0;
		decCount = 0;
		decBit = 0;
		decByte = '0;
		void'($urandom(seed));

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// state right after reset
		@(negedge clk);
		compareValue("tx", 32'd1, 32'(tx));
		compareValue("busy", 32'd0, 32'(busy));
		compareValue("fifoStat.empty", 32'd1, 32'(fifoStat.empty));
		compareValue("fifoStat.full", 32'd0, 32'(fifoStat.full));
		compareValue("fifoStat.level", 32'd0, 32'(fifoStat.level));

		sendRandomBytes(bytesPerRun); // divisor 3
		waitForIdle();

		// overfill, 16 queued plus one already on the line
		acceptedCount = 0;
		droppedCount = 0;
		sawFull = 1'b0;
		sendBurst(burstLen);
		compareValue("fifoStat.full seen", 32'd1, 32'(sawFull));
		compareValue("accepted writes", 32'(`UART_FIFO_DEPTH + 1), 32'(acceptedCount));
		compareValue("dropped writes", 32'(burstLen - `UART_FIFO_DEPTH - 1), 32'(droppedCount));
		@(negedge clk);
		compareValue("fifoStat.level", 32'(`UART_FIFO_DEPTH), 32'(fifoStat.level)); // still packed
		waitForIdle();

		setDivisor(0);
		sendRandomBytes(bytesPerRun);
		waitForIdle();

		setDivisor(maxDiv);
		sendRandomBytes(bytesPerRun);
		waitForIdle();

		compareValue("fifoStat.level", 32'd0, 32'(fifoStat.level));
		if (expected.size() == 0)
		begin
			$display("STATUS: PASS");
			$finish;
		end
		else
			stopWithError("accepted bytes were never sent on the line");
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+common
common/uartPkg.sv
source/baudGen.sv
source/txFifo.sv
uart/txControl.sv
uart/txShifter.sv
source/uartTxTop.sv
tb/tbUartTx.sv

// File: run.sh
#!/bin/sh
# build the UART transmitter testbench with Verilator, run it, check the log

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbUartTx \
	--Mdir obj_dir -o simUartTx &&
./obj_dir/simUartTx > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
